/* filelist.f */
hdl/cube_pkg.sv
hdl/display_timings.sv
hdl/draw_line.sv
hdl/cube_drawer.sv
hdl/framebuffer.sv
hdl/linebuffer.sv
hdl/scanout.sv
hdl/cube_display.sv
sim/cube_display_tb.sv

/* hdl/cube_display.sv */
// wireframe cube drawn into a 160x120 framebuffer, shown 4x scaled at 640x480
// the host starts each drawing with draw_req and picks its colour index

`timescale 1ns/1ps

module cube_display (
    input  logic              clk_pix,
    input  logic              rst,
    input  logic              draw_req,
    input  cube_pkg::cidx_t   draw_colr,
    output logic              draw_ack,
    output logic              hsync,
    output logic              vsync,
    output logic              de,
    output cube_pkg::chan_t   red,
    output cube_pkg::chan_t   green,
    output cube_pkg::chan_t   blue
);
    import cube_pkg::*;

    screen_coord_t sy;
    logic          tm_hsync, tm_vsync, tm_de, frame_start;
    logic          line_req, line_ack, drawing;
    fb_coord_t     x0, y0, x1, y1, px, py;
    cidx_t         wr_cidx, fb_rdata;
    fb_addr_t      fb_raddr;

    display_timings display_timings_i (
        .clk_pix,
        .rst,
        .sx(),
        .sy,
        .hsync(tm_hsync),
        .vsync(tm_vsync),
        .de(tm_de),
        .frame_start
    );

    cube_drawer cube_drawer_i (
        .clk_pix,
        .rst,
        .draw_req,
        .draw_colr,
        .draw_ack,
        .line_req,
        .line_ack,
        .x0,
        .y0,
        .x1,
        .y1,
        .wr_cidx
    );

    draw_line draw_line_i (
        .clk_pix,
        .rst,
        .line_req,
        .line_ack,
        .x0,
        .y0,
        .x1,
        .y1,
        .px,
        .py,
        .drawing
    );

    framebuffer framebuffer_i (
        .clk_pix,
        .px,
        .py,
        .we(drawing),
        .wdata(wr_cidx),
        .raddr(fb_raddr),
        .rdata(fb_rdata)
    );

    scanout scanout_i (
        .clk_pix,
        .rst,
        .sy,
        .de(tm_de),
        .hsync(tm_hsync),
        .vsync(tm_vsync),
        .frame_start,
        .fb_raddr,
        .fb_rdata,
        .hsync_out(hsync),
        .vsync_out(vsync),
        .de_out(de),
        .red,
        .green,
        .blue
    );

endmodule

/* hdl/cube_drawer.sv */
// draw sequencer for the nine cube edges, started by the host req/ack pair
// feeds each edge to draw_line and passes the host colour to the framebuffer

`timescale 1ns/1ps

module cube_drawer (
    input  logic                clk_pix,
    input  logic                rst,
    input  logic                draw_req,
    input  cube_pkg::cidx_t     draw_colr,
    output logic                draw_ack,
    output logic                line_req,
    input  logic                line_ack,
    output cube_pkg::fb_coord_t x0,
    output cube_pkg::fb_coord_t y0,
    output cube_pkg::fb_coord_t x1,
    output cube_pkg::fb_coord_t y1,
    output cube_pkg::cidx_t     wr_cidx
);
    import cube_pkg::*;

    drawer_state_t state;
    logic [3:0]    edge_id;
    logic [31:0]   edge_xy;   // {x0, y0, x1, y1}

    // front face, back face corner, then the depth edges
    always_comb begin
        case (edge_id)
            4'd0:    edge_xy = {8'd65,  8'd45, 8'd115, 8'd45};
            4'd1:    edge_xy = {8'd115, 8'd45, 8'd115, 8'd95};
            4'd2:    edge_xy = {8'd115, 8'd95, 8'd65,  8'd95};
            4'd3:    edge_xy = {8'd65,  8'd95, 8'd65,  8'd45};
            4'd4:    edge_xy = {8'd65,  8'd95, 8'd45,  8'd75};
            4'd5:    edge_xy = {8'd45,  8'd75, 8'd45,  8'd25};
            4'd6:    edge_xy = {8'd45,  8'd25, 8'd65,  8'd45};
            4'd7:    edge_xy = {8'd45,  8'd25, 8'd95,  8'd25};
            4'd8:    edge_xy = {8'd95,  8'd25, 8'd115, 8'd45};
            default: edge_xy = '0;
        endcase
    end

    always_ff @(posedge clk_pix) begin
        if (rst) begin
            state    <= DR_IDLE;
            edge_id  <= '0;
            draw_ack <= 1'b0;
            line_req <= 1'b0;
        end else begin
            case (state)
                DR_LOAD: begin
                    {x0, y0, x1, y1} <= edge_xy;
                    line_req <= 1'b1;
                    state    <= DR_DRAW;
                end
                DR_DRAW: begin
                    if (line_req) begin
                        if (line_ack) line_req <= 1'b0;
                    end else if (!line_ack) begin   // line handshake fully closed
                        if (edge_id == 4'(EDGE_CNT - 1)) begin
                            draw_ack <= 1'b1;
                            state    <= DR_FINISH;
                        end else begin
                            edge_id <= edge_id + 1'b1;
                            state   <= DR_LOAD;
                        end
                    end
                end
                DR_FINISH: begin
                    if (!draw_req) begin
                        draw_ack <= 1'b0;
                        state    <= DR_IDLE;
                    end
                end
                default: begin
                    if (draw_req) begin
                        wr_cidx <= draw_colr;   // held for the whole cube
                        edge_id <= '0;
                        state   <= DR_LOAD;
                    end
                end
            endcase
        end
    end

    a_edge_range: assert property (@(posedge clk_pix) disable iff (rst)
        edge_id < 4'(EDGE_CNT));

endmodule

/* hdl/cube_pkg.sv */
// shared sizes, timing constants and types for the cube display
// imported by every module of the design and by the testbench

package cube_pkg;

    // bit widths behind the typedefs
    localparam int FB_ADDRW = 15;
    localparam int FB_CORDW = 8;
    localparam int CIDX_W   = 2;
    localparam int LB_BPC   = 4;   // bits per colour channel

    typedef logic [9:0]            screen_coord_t;
    typedef logic [FB_CORDW-1:0]   fb_coord_t;
    typedef logic [FB_ADDRW-1:0]   fb_addr_t;
    typedef logic [CIDX_W-1:0]     cidx_t;
    typedef logic [3*LB_BPC-1:0]   colr_t;   // {red, green, blue}
    typedef logic [LB_BPC-1:0]     chan_t;

    // 640x480 at 60 Hz, syncs active low
    localparam screen_coord_t H_RES   = 640;
    localparam screen_coord_t H_FP    = 16;
    localparam screen_coord_t H_SYNC  = 96;
    localparam screen_coord_t H_BP    = 48;
    localparam screen_coord_t H_TOTAL = H_RES + H_FP + H_SYNC + H_BP;
    localparam screen_coord_t V_RES   = 480;
    localparam screen_coord_t V_FP    = 10;
    localparam screen_coord_t V_SYNC  = 2;
    localparam screen_coord_t V_BP    = 33;
    localparam screen_coord_t V_TOTAL = V_RES + V_FP + V_SYNC + V_BP;

    localparam fb_coord_t FB_WIDTH  = 160;
    localparam fb_coord_t FB_HEIGHT = 120;
    localparam fb_addr_t  FB_PIXELS = 19200;
    localparam string     PALETTE_FILE = "hdl/palette.mem";

    localparam int LB_SCALE = 4;   // same factor in x and y
    localparam int EDGE_CNT = 9;

    typedef enum logic [1:0] {DR_IDLE, DR_LOAD, DR_DRAW, DR_FINISH} drawer_state_t;
    typedef enum logic [1:0] {LN_IDLE, LN_INIT, LN_DRAW} line_state_t;

endpackage

/* hdl/display_timings.sv */
// 640x480 raster counters with registered syncs and data enable
// frame_start marks the first cycle of vertical blanking

`timescale 1ns/1ps

module display_timings (
    input  logic                    clk_pix,
    input  logic                    rst,
    output cube_pkg::screen_coord_t sx,
    output cube_pkg::screen_coord_t sy,
    output logic                    hsync,
    output logic                    vsync,
    output logic                    de,
    output logic                    frame_start
);
    import cube_pkg::*;

    always_ff @(posedge clk_pix) begin
        if (rst) begin
            sx <= '0;
            sy <= '0;
        end else if (sx == H_TOTAL - 1'b1) begin
            sx <= '0;
            sy <= (sy == V_TOTAL - 1'b1) ? '0 : sy + 1'b1;
        end else begin
            sx <= sx + 1'b1;
        end
    end

    // one cycle behind sx/sy
    always_ff @(posedge clk_pix) begin
        if (rst) begin
            hsync <= 1'b1;
            vsync <= 1'b1;
            de    <= 1'b0;
        end else begin
            hsync <= ~(sx >= H_RES + H_FP && sx < H_RES + H_FP + H_SYNC);
            vsync <= ~(sy >= V_RES + V_FP && sy < V_RES + V_FP + V_SYNC);
            de    <= (sx < H_RES && sy < V_RES);
        end
    end

    always_comb frame_start = (sy == V_RES && sx == '0);

    a_sx_range: assert property (@(posedge clk_pix) disable iff (rst) sx < H_TOTAL);

endmodule

/* hdl/draw_line.sv */
// Bresenham line drawer, one pixel per clock while drawing is high
// started by line_req, answers with line_ack once the end point is out

`timescale 1ns/1ps

module draw_line (
    input  logic                clk_pix,
    input  logic                rst,
    input  logic                line_req,
    output logic                line_ack,
    input  cube_pkg::fb_coord_t x0,
    input  cube_pkg::fb_coord_t y0,
    input  cube_pkg::fb_coord_t x1,
    input  cube_pkg::fb_coord_t y1,
    output cube_pkg::fb_coord_t px,
    output cube_pkg::fb_coord_t py,
    output logic                drawing
);
    import cube_pkg::*;

    line_state_t        state;
    fb_coord_t          adx, ady;        // absolute deltas
    logic signed [10:0] dx, dy, err, e2;
    logic               right, down;     // step directions
    logic               step_x, step_y;

    always_comb begin
        adx    = (x0 < x1) ? x1 - x0 : x0 - x1;
        ady    = (y0 < y1) ? y1 - y0 : y0 - y1;
        e2     = err + err;
        step_x = (e2 >= dy);
        step_y = (e2 <= dx);
    end

    always_ff @(posedge clk_pix) begin
        if (rst) begin
            state    <= LN_IDLE;
            line_ack <= 1'b0;
        end else begin
            case (state)
                LN_INIT: begin
                    px    <= x0;
                    py    <= y0;
                    right <= (x0 < x1);
                    down  <= (y0 < y1);
                    dx    <= $signed({3'b000, adx});
                    dy    <= -$signed({3'b000, ady});   // dy kept negative
                    err   <= $signed({3'b000, adx}) - $signed({3'b000, ady});
                    state <= LN_DRAW;
                end
                LN_DRAW: begin
                    if (px == x1 && py == y1) begin
                        line_ack <= 1'b1;
                        state    <= LN_IDLE;
                    end else begin
                        if (step_x) px <= right ? px + 1'b1 : px - 1'b1;
                        if (step_y) py <= down ? py + 1'b1 : py - 1'b1;
                        err <= err + (step_x ? dy : 11'sd0) + (step_y ? dx : 11'sd0);
                    end
                end
                default: begin
                    if (line_ack) begin
                        if (!line_req) line_ack <= 1'b0;   // handshake closes
                    end else if (line_req) begin
                        state <= LN_INIT;
                    end
                end
            endcase
        end
    end

    always_comb drawing = (state == LN_DRAW);

    // the sequencer must keep line_req up until line_ack answers
    a_req_held: assert property (@(posedge clk_pix) disable iff (rst)
        $fell(line_req) |-> state == LN_IDLE);

endmodule

/* hdl/framebuffer.sv */
// 160x120 framebuffer of colour indices, one write and one read port
// writes land one cycle after their coordinate, reads return one cycle late

`timescale 1ns/1ps

module framebuffer (
    input  logic                clk_pix,
    input  cube_pkg::fb_coord_t px,
    input  cube_pkg::fb_coord_t py,
    input  logic                we,
    input  cube_pkg::cidx_t     wdata,
    input  cube_pkg::fb_addr_t  raddr,
    output cube_pkg::cidx_t     rdata
);
    import cube_pkg::*;

    cidx_t    mem [FB_PIXELS];
    fb_addr_t waddr;
    logic     we_q;
    cidx_t    wdata_q;

    initial begin
        for (int i = 0; i < FB_PIXELS; i++) mem[i] = '0;   // blank screen
    end

    // row * width + column, kept in step with we and data
    always_ff @(posedge clk_pix) begin
        waddr   <= fb_addr_t'(py) * fb_addr_t'(FB_WIDTH) + fb_addr_t'(px);
        we_q    <= we;
        wdata_q <= wdata;
    end

    always_ff @(posedge clk_pix) begin
        if (we_q) mem[waddr] <= wdata_q;
        rdata <= mem[raddr];
    end

    // drawer coordinates must stay on the framebuffer
    a_wr_bounds: assert property (@(posedge clk_pix) we |-> px < FB_WIDTH && py < FB_HEIGHT);

endmodule

/* hdl/linebuffer.sv */
// one framebuffer row of colours, replayed LB_SCALE times per pixel and per line
// data_req asks for the next row, frame_start rewinds everything

`timescale 1ns/1ps

module linebuffer (
    input  logic            clk_pix,
    input  logic            en_in,
    input  cube_pkg::colr_t din,
    input  logic            en_out,
    input  logic            frame_start,
    output logic            data_req,
    output cube_pkg::colr_t dout
);
    import cube_pkg::*;

    colr_t     mem [FB_WIDTH];
    fb_coord_t addr_in, addr_out;
    logic [1:0] rep_h, rep_v;   // pixel and line repeat counts

    always_ff @(posedge clk_pix) begin
        if (en_in) mem[addr_in] <= din;
    end

    always_ff @(posedge clk_pix) begin
        if (frame_start) addr_in <= '0;
        else if (en_in) addr_in <= (addr_in == FB_WIDTH - 1'b1) ? '0 : addr_in + 1'b1;
    end

    always_ff @(posedge clk_pix) begin
        data_req <= 1'b0;
        if (frame_start) begin
            addr_out <= '0;
            rep_h    <= '0;
            rep_v    <= '0;
            data_req <= 1'b1;   // first row is fetched during vblank
        end else if (en_out) begin
            if (rep_h == 2'(LB_SCALE - 1)) begin
                rep_h <= '0;
                if (addr_out == FB_WIDTH - 1'b1) begin   // end of a scaled line
                    addr_out <= '0;
                    if (rep_v == 2'(LB_SCALE - 1)) begin
                        rep_v    <= '0;
                        data_req <= 1'b1;
                    end else begin
                        rep_v <= rep_v + 1'b1;
                    end
                end else begin
                    addr_out <= addr_out + 1'b1;
                end
            end else begin
                rep_h <= rep_h + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_pix) dout <= mem[addr_out];   // one cycle of latency

endmodule

/* hdl/palette.mem */
// one 12-bit rgb colour per line, 4 bits per channel, indexed by colour index
136
fc3
3cf
f5a

/* hdl/scanout.sv */
// reads framebuffer rows into the line buffer through the palette
// and lines the syncs up with the scaled colour output

`timescale 1ns/1ps

module scanout (
    input  logic                    clk_pix,
    input  logic                    rst,
    input  cube_pkg::screen_coord_t sy,
    input  logic                    de,
    input  logic                    hsync,
    input  logic                    vsync,
    input  logic                    frame_start,
    output cube_pkg::fb_addr_t      fb_raddr,
    input  cube_pkg::cidx_t         fb_rdata,
    output logic                    hsync_out,
    output logic                    vsync_out,
    output logic                    de_out,
    output cube_pkg::chan_t         red,
    output cube_pkg::chan_t         green,
    output cube_pkg::chan_t         blue
);
    import cube_pkg::*;

    logic      lb_data_req;
    fb_coord_t cnt_h;                     // pixels fetched in this row
    logic      en_in_2, en_in_1, en_in;   // fetch enable, delayed
    cidx_t     cidx_q;
    colr_t     palette [2**CIDX_W];
    colr_t     colr_q, lb_dout;

    initial $readmemh(PALETTE_FILE, palette);

    always_ff @(posedge clk_pix) begin
        if (rst) begin
            cnt_h    <= FB_WIDTH;   // idle
            fb_raddr <= '0;
        end else begin
            if (frame_start) fb_raddr <= '0;
            if (lb_data_req && sy != V_RES - 1'b1) begin   // nothing after the last line
                cnt_h <= '0;
            end else if (cnt_h < FB_WIDTH) begin
                cnt_h    <= cnt_h + 1'b1;
                fb_raddr <= (fb_raddr == FB_PIXELS - 1'b1) ? '0 : fb_raddr + 1'b1;
            end
        end
    end

    // ram read, index register and palette register
    always_ff @(posedge clk_pix) begin
        if (rst) begin
            en_in_2 <= 1'b0;
            en_in_1 <= 1'b0;
            en_in   <= 1'b0;
        end else begin
            en_in_2 <= (cnt_h < FB_WIDTH);
            en_in_1 <= en_in_2;
            en_in   <= en_in_1;
        end
    end

    always_ff @(posedge clk_pix) begin
        cidx_q <= fb_rdata;
        colr_q <= palette[cidx_q];
    end

    linebuffer linebuffer_i (
        .clk_pix,
        .en_in,
        .din(colr_q),
        .en_out(de),
        .frame_start,
        .data_req(lb_data_req),
        .dout(lb_dout)
    );

    // match the line buffer read latency
    always_ff @(posedge clk_pix) begin
        if (rst) begin
            hsync_out <= 1'b1;
            vsync_out <= 1'b1;
            de_out    <= 1'b0;
        end else begin
            hsync_out <= hsync;
            vsync_out <= vsync;
            de_out    <= de;
        end
    end

    always_comb {red, green, blue} = de_out ? lb_dout : '0;   // black in blanking

endmodule

/* run_sim.sh */
#!/bin/sh
verilator --binary --assert --top-module cube_display_tb -f filelist.f -o cube_sim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/cube_sim > sim.log 2>&1 || true
cat sim.log
grep -qx "Everything OK" sim.log && exit 0 || exit 1

/* sim/cube_display_tb.sv */
// testbench for cube_display with sync timing, the blank framebuffer and two drawings
// a table of steps is applied in order, each step samples one whole output frame

`timescale 1ns/1ps

module cube_display_tb;
    import cube_pkg::*;

    localparam int H_PIX        = int'(H_RES);
    localparam int V_PIX        = int'(V_RES);
    localparam int LINE_CYCLES  = int'(H_TOTAL);
    localparam int FRAME_LINES  = int'(V_TOTAL);
    localparam int HS_WIDTH     = int'(H_SYNC);
    localparam int VS_LINES     = int'(V_SYNC);
    localparam int FRAME_CYCLES = LINE_CYCLES * FRAME_LINES;
    localparam int DE_PER_FRAME = H_PIX * V_PIX;
    localparam int ACK_WAIT     = 5000;   // cycles allowed for one whole cube

    // step kinds
    localparam int K_SYNC  = 0;
    localparam int K_BLANK = 1;
    localparam int K_DRAW  = 2;

    localparam int NSTEP = 4;
    localparam int STEP_KIND [NSTEP] = '{K_SYNC, K_BLANK, K_DRAW, K_DRAW};
    localparam int STEP_CIDX [NSTEP] = '{0, 0, 2, 3};   // index expected on the edges

    // vertices, midpoints of the straight edges, then background
    localparam int NPT = 16;
    localparam int PT_X [NPT] = '{65, 115, 115, 65, 45, 45, 95,
                                  90, 115, 90, 65, 45, 70, 10, 90, 150};
    localparam int PT_Y [NPT] = '{45, 45, 95, 95, 75, 25, 25,
                                  45, 70, 95, 70, 50, 25, 10, 70, 110};
    localparam int PT_EDGE [NPT] = '{1, 1, 1, 1, 1, 1, 1,
                                     1, 1, 1, 1, 1, 1, 0, 0, 0};

    logic  clk_pix, rst, draw_req;
    cidx_t draw_colr;
    logic  draw_ack, hsync, vsync, de;
    chan_t red, green, blue;

    colr_t       ref_palette [2**CIDX_W];
    colr_t       frame_pix [DE_PER_FRAME];   // one captured visible frame
    logic [31:0] rng;
    int          errors, step_errors, steps_failed;
    int          frame_cyc, hs_falls, hs_low, vs_low, de_cnt, blank_bad;
    int          line_min, line_max;

    cube_display cube_display_i (
        .clk_pix,
        .rst,
        .draw_req,
        .draw_colr,
        .draw_ack,
        .hsync,
        .vsync,
        .de,
        .red,
        .green,
        .blue
    );

    initial begin
        clk_pix = 1'b0;
        forever #5 clk_pix = ~clk_pix;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] v;
        v = s;
        v = v ^ (v << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    function automatic int pix_index(input int x, input int y, input int i, input int j);
        return (y * LB_SCALE + j) * H_PIX + x * LB_SCALE + i;
    endfunction

    function automatic int frames_for(input int kind);
        return (kind == K_DRAW) ? 4 : 2;   // a drawing adds the handshake and a skipped frame
    endfunction

    function automatic string kind_name(input int kind);
        case (kind)
            K_SYNC:  return "sync timing";
            K_BLANK: return "blank framebuffer";
            default: return "draw";
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR %s: got %h, expected %h", name, got, exp);
            errors++;
            step_errors++;
        end
    endtask

    task automatic note_failure(input string what);
        $display("handshake problem: %s", what);
        errors++;
        step_errors++;
    endtask

    // returns on the first cycle with vsync low
    task automatic wait_vsync_fall();
        logic prev;
        do begin
            prev = vsync;
            @(negedge clk_pix);
        end while (!(prev && !vsync));
    endtask

    // samples one frame between vsync falls and tracks the position from de
    task automatic capture_frame();
        logic prev_hs, prev_de, prev_vs;
        int   ox, oy, last_fall, len;
        bit   done;
        frame_cyc = 0;
        hs_falls  = 0;
        hs_low    = 0;
        vs_low    = 0;
        de_cnt    = 0;
        blank_bad = 0;
        line_min  = 1 << 30;
        line_max  = 0;
        last_fall = -1;
        ox        = 0;
        oy        = 0;
        prev_hs   = hsync;
        prev_de   = 1'b0;
        done      = 1'b0;
        while (!done) begin
            frame_cyc++;
            if (!vsync) vs_low++;
            if (!hsync) hs_low++;
            if (prev_hs && !hsync) begin
                hs_falls++;
                if (last_fall >= 0) begin
                    len = frame_cyc - last_fall;
                    if (len < line_min) line_min = len;
                    if (len > line_max) line_max = len;
                end
                last_fall = frame_cyc;
            end
            if (de) begin
                de_cnt++;
                if (ox < H_PIX && oy < V_PIX) frame_pix[oy * H_PIX + ox] = {red, green, blue};
                ox++;
            end else begin
                if ({red, green, blue} != '0) blank_bad++;   // must be black
                if (prev_de) begin
                    ox = 0;
                    oy++;
                end
            end
            prev_hs = hsync;
            prev_de = de;
            prev_vs = vsync;
            @(negedge clk_pix);
            done = prev_vs && !vsync;
        end
    endtask

    task automatic check_sync();
        check_value("frame length in cycles", frame_cyc, FRAME_CYCLES);
        check_value("hsync falls per frame", hs_falls, FRAME_LINES);
        check_value("shortest hsync period", line_min, LINE_CYCLES);
        check_value("longest hsync period", line_max, LINE_CYCLES);
        check_value("hsync low cycles per frame", hs_low, FRAME_LINES * HS_WIDTH);
        check_value("vsync low cycles per frame", vs_low, VS_LINES * LINE_CYCLES);
        check_value("de cycles per frame", de_cnt, DE_PER_FRAME);
    endtask

    // two random subpixels of each 4x4 block
    task automatic check_points(input int edge_idx);
        int    a_idx, b_idx;
        cidx_t exp_c;
        colr_t a, b;
        for (int p = 0; p < NPT; p++) begin
            exp_c = (PT_EDGE[p] != 0) ? cidx_t'(edge_idx) : cidx_t'(0);
            rng   = xorshift(rng);
            a_idx = pix_index(PT_X[p], PT_Y[p], int'(rng[1:0]), int'(rng[3:2]));
            b_idx = pix_index(PT_X[p], PT_Y[p], int'(rng[5:4]), int'(rng[7:6]));
            a     = frame_pix[a_idx];
            b     = frame_pix[b_idx];
            check_value($sformatf("{red,green,blue} at fb (%0d,%0d)", PT_X[p], PT_Y[p]),
                        32'(a), 32'(ref_palette[exp_c]));
            check_value($sformatf("{red,green,blue} second subpixel at fb (%0d,%0d)",
                        PT_X[p], PT_Y[p]), 32'(b), 32'(ref_palette[exp_c]));
        end
    endtask

    task automatic run_handshake(input int cidx);
        int delay, hold, wait_cyc;
        rng   = xorshift(rng);
        delay = 1 + int'(rng[3:0]);
        hold  = 1 + int'(rng[9:4]);   // host keeps req up a while after ack
        repeat (delay) begin
            @(negedge clk_pix);
            if (draw_ack) note_failure("draw_ack was high before draw_req rose");
        end
        draw_colr = cidx_t'(cidx);
        draw_req  = 1'b1;
        wait_cyc  = 0;
        while (!draw_ack && wait_cyc < ACK_WAIT) begin
            @(negedge clk_pix);
            wait_cyc++;
        end
        if (!draw_ack) begin
            note_failure("draw_ack never rose after draw_req");
        end else begin
            repeat (hold) begin
                @(negedge clk_pix);
                if (!draw_ack) note_failure("draw_ack fell while draw_req was still held");
            end
        end
        draw_req = 1'b0;
        wait_cyc = 0;
        while (draw_ack && wait_cyc < 16) begin
            @(negedge clk_pix);
            wait_cyc++;
        end
        if (draw_ack) note_failure("draw_ack stayed high after draw_req fell");
    endtask

    initial begin
        rst          = 1'b1;
        draw_req     = 1'b0;
        draw_colr    = '0;
        rng          = 32'd28544;
        errors       = 0;
        steps_failed = 0;
        $readmemh(PALETTE_FILE, ref_palette);
        repeat (10) @(negedge clk_pix);
        rst = 1'b0;
        for (int s = 0; s < NSTEP; s++) begin
            step_errors = 0;
            if (STEP_KIND[s] == K_DRAW) begin
                run_handshake(STEP_CIDX[s]);
                wait_vsync_fall();   // this frame may show a half drawn cube
            end
            wait_vsync_fall();
            capture_frame();
            check_value("red/green/blue nonzero outside de", blank_bad, 0);
            if (STEP_KIND[s] == K_SYNC) check_sync();
            else check_points(STEP_CIDX[s]);
            if (step_errors != 0) steps_failed++;
            $display("step %0d (%s, index %0d) finished with %0d mismatches",
                     s, kind_name(STEP_KIND[s]), STEP_CIDX[s], step_errors);
        end
        $display("steps run %0d, steps failed %0d, total mismatches %0d",
                 NSTEP, steps_failed, errors);
        if (errors == 0) $display("Everything OK");
        else $display("Something failed");
        $finish;
    end

    // watchdog sized from the step table plus one frame of margin
    initial begin
        int frames;
        int limit;
        frames = 1;
        for (int s = 0; s < NSTEP; s++) frames += frames_for(STEP_KIND[s]);
        limit = frames * FRAME_CYCLES;
        repeat (limit) @(posedge clk_pix);
        $display("timeout: run did not finish within %0d cycles", limit);
        $display("Something failed");
        $finish;
    end

endmodule
